// File: sim.f
+incdir+include
rtl/cache_pkg.sv
rtl/cache_ifs.sv
rtl/sram_1p.sv
rtl/tag_array.sv
rtl/data_array.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
bench/cache_asserts.sv
bench/cache_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = cache_tb
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Checks failed
PASS_MSG = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended early"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/cache_tb.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_tb;

    localparam int          cycle_limit = 3000;         // five short tests plus margin
    localparam logic [2:0]  lfsr_seed   = 3'b111;
    localparam logic [31:0] fill_const  = 32'h5a3c_0000;

    logic                       clk, reset;
    logic                       valid, op;
    logic [`CACHE_INDEX_W-1:0]  index;
    logic [`CACHE_TAG_W-1:0]    tag;
    logic [`CACHE_OFFSET_W-1:0] offset;
    logic [`CACHE_STRB_W-1:0]   wstrb;
    logic [`CACHE_WORD_W-1:0]   wdata, rdata;
    logic                       addr_ok, data_ok;
    logic                       rd_req, rd_rdy, ret_valid, ret_last;
    logic [`CACHE_WORD_W-1:0]   rd_addr, ret_data;
    logic                       wr_req, wr_rdy;
    logic [`CACHE_WORD_W-1:0]   wr_addr;
    logic [`CACHE_BLOCK_W-1:0]  wr_data;

    // memory model state
    logic [31:0]  model_mem [logic [31:0]];   // only written-back words
    int           rd_count, wr_count, cur_beat, cycles;
    logic [31:0]  last_rd_addr, last_wr_addr;
    logic [127:0] last_wr_block;
    logic [2:0]   lfsr_model;

    cache_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] pattern_word(input logic [31:0] addr);
        return addr + fill_const;
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        if (model_mem.exists(addr)) return model_mem[addr];
        return pattern_word(addr);
    endfunction

    // rotate right with the old top xor bottom as the new middle bit
    function automatic logic [2:0] next_lfsr(input logic [2:0] s);
        logic [2:0] r;
        r    = {s[0], s[2:1]};
        r[1] = s[2] ^ s[0];
        return r;
    endfunction

    function automatic logic [31:0] make_addr(input logic [19:0] t, input logic [7:0] i,
                                              input logic [1:0] b);
        return {t, i, b, 2'b00};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] new_w,
                                                input logic [3:0] strb);
        logic [31:0] m;
        for (int i = 0; i < 4; i++) begin
            m[i*8 +: 8] = strb[i] ? new_w[i*8 +: 8] : old[i*8 +: 8];
        end
        return m;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp)
            else stop_on_error($sformatf("mismatch at %0t: %s is %h, expected %h",
                                         $time, what, got, exp));
    endtask

    // take one write-back block and raise wr_rdy a cycle later
    task automatic serve_write();
        last_wr_addr  = wr_addr;
        last_wr_block = wr_data;
        wr_count++;
        for (int b = 0; b < 4; b++) begin
            model_mem[wr_addr + 32'(4 * b)] = wr_data[b*32 +: 32];
        end
        @(posedge clk);
        #2;
        wr_rdy = 1'b1;
        @(posedge clk);
        #2;
        wr_rdy = 1'b0;
    endtask

    task automatic serve_read();
        logic [31:0] base;
        base         = rd_addr;
        last_rd_addr = rd_addr;
        rd_count++;
        @(posedge clk);
        #2;
        rd_rdy = 1'b1;
        @(posedge clk);
        #2;
        rd_rdy = 1'b0;
        for (int b = 0; b < 4; b++) begin    // bank 0 first
            cur_beat  = b;
            ret_valid = 1'b1;
            ret_last  = (b == 3);
            ret_data  = model_word(base + 32'(4 * b));
            @(posedge clk);
            #2;
        end
        ret_valid  = 1'b0;
        ret_last   = 1'b0;
        lfsr_model = next_lfsr(lfsr_model);   // the last beat steps the LFSR
    endtask

    initial begin
        rd_rdy        = 1'b0;
        ret_valid     = 1'b0;
        ret_last      = 1'b0;
        ret_data      = '0;
        wr_rdy        = 1'b0;
        rd_count      = 0;
        wr_count      = 0;
        cur_beat      = 0;
        last_rd_addr  = '0;
        last_wr_addr  = '0;
        last_wr_block = '0;
        lfsr_model    = lfsr_seed;
        forever begin
            @(posedge clk);
            #2;
            if (wr_req) serve_write();
            if (rd_req) serve_read();
        end
    end

    // one CPU request with its data, cycles to data_ok and the beat seen then
    task automatic access(input logic wr, input logic [31:0] addr, input logic [3:0] strb,
                          input logic [31:0] data, output logic [31:0] rd, output int lat,
                          output int beat);
        @(posedge clk);
        #2;
        valid  = 1'b1;
        op     = wr;
        tag    = addr[31:12];
        index  = addr[11:4];
        offset = addr[3:0];
        wstrb  = strb;
        wdata  = data;
        @(negedge clk);
        while (!addr_ok) @(negedge clk);
        @(posedge clk);   // accepting edge
        #2;
        valid = 1'b0;
        lat   = 0;
        @(negedge clk);
        while (!data_ok) begin
            lat++;
            @(negedge clk);
        end
        rd   = rdata;
        beat = cur_beat;
        while (!addr_ok) @(negedge clk);   // let a refill finish
    endtask

    task automatic reset_state();
        @(negedge clk);
        assert (addr_ok === 1'b1) else stop_on_error("addr_ok is not high after reset");
        assert (data_ok === 1'b0 && rd_req === 1'b0 && wr_req === 1'b0)
            else stop_on_error("data_ok, rd_req or wr_req is high after reset");
    endtask

    task automatic read_miss_then_hit();
        logic [31:0] a, rd;
        int          lat, beat, reads;
        a     = make_addr(20'h12345, 8'h10, 2'd2);
        reads = rd_count;
        access(1'b0, a, 4'h0, 32'h0, rd, lat, beat);
        assert (rd_count == reads + 1) else stop_on_error("read miss raised no rd_req");
        check_word(last_rd_addr, {a[31:4], 4'h0}, "rd_addr");
        assert (beat == 2) else stop_on_error("read miss answered on the wrong beat");
        check_word(rd, pattern_word(a), "read miss data");
        access(1'b0, a - 32'd4, 4'h0, 32'h0, rd, lat, beat);
        assert (lat == 0 && rd_count == reads + 1)
            else stop_on_error("second read of a resident block was not a hit");
        check_word(rd, pattern_word(a - 32'd4), "read hit data");
    endtask

    task automatic write_hit_strobes();
        logic [31:0] a, rd;
        int          lat, beat, reads;
        a     = make_addr(20'h12345, 8'h10, 2'd1);
        reads = rd_count;
        access(1'b1, a, 4'b0101, 32'haabb_ccdd, rd, lat, beat);
        assert (lat == 0 && rd_count == reads) else stop_on_error("write hit was not a hit");
        access(1'b0, a, 4'h0, 32'h0, rd, lat, beat);
        assert (lat == 0) else stop_on_error("read after write hit was not a hit");
        check_word(rd, merge_bytes(pattern_word(a), 32'haabb_ccdd, 4'b0101), "strobed word");
    endtask

    task automatic write_miss_merge();
        logic [31:0] a, rd;
        int          lat, beat, reads;
        a     = make_addr(20'h0abcd, 8'h20, 2'd3);
        reads = rd_count;
        access(1'b1, a, 4'b1100, 32'h1122_3344, rd, lat, beat);
        assert (lat == 0) else stop_on_error("write miss data_ok came late");
        assert (rd_count == reads + 1) else stop_on_error("write miss raised no rd_req");
        check_word(last_rd_addr, {a[31:4], 4'h0}, "rd_addr");
        access(1'b0, a, 4'h0, 32'h0, rd, lat, beat);
        assert (lat == 0) else stop_on_error("read after write miss was not a hit");
        check_word(rd, merge_bytes(pattern_word(a), 32'h1122_3344, 4'b1100), "merged word");
    endtask

    task automatic dirty_eviction();
        logic [19:0]  way_tag [2];
        logic         way_dirty [2];
        logic [31:0]  way_word [2];
        logic [31:0]  a, rd, vaddr, store;
        logic [127:0] exp_block;
        logic         vw;
        int           lat, beat, reads, writes, n;
        way_dirty[0] = 1'b0;
        way_dirty[1] = 1'b0;
        n = 0;
        // fresh tags into one set until both ways are dirty
        while (!(way_dirty[0] && way_dirty[1]) && n < 6) begin
            vw     = lfsr_model[0];
            a      = make_addr(20'h40000 + 20'(n), 8'h30, 2'd0);
            store  = 32'hd000_0000 + 32'(n);
            writes = wr_count;
            access(1'b1, a, 4'hf, store, rd, lat, beat);
            if (way_dirty[vw]) begin
                assert (wr_count == writes + 1)
                    else stop_on_error("dirty victim not written back");
                check_word(last_wr_addr, make_addr(way_tag[vw], 8'h30, 2'd0), "wr_addr");
            end else begin
                assert (wr_count == writes) else stop_on_error("clean victim was written back");
            end
            way_tag[vw]   = a[31:12];
            way_dirty[vw] = 1'b1;
            way_word[vw]  = store;
            n++;
        end
        vw        = lfsr_model[0];
        vaddr     = make_addr(way_tag[vw], 8'h30, 2'd0);
        exp_block = {pattern_word(vaddr + 32'd12), pattern_word(vaddr + 32'd8),
                     pattern_word(vaddr + 32'd4), way_word[vw]};
        a      = make_addr(20'h40100, 8'h30, 2'd1);
        writes = wr_count;
        access(1'b0, a, 4'h0, 32'h0, rd, lat, beat);
        assert (wr_count == writes + 1) else stop_on_error("third tag evicted no dirty block");
        check_word(last_wr_addr, vaddr, "victim address");
        for (int b = 0; b < 4; b++) begin
            check_word(last_wr_block[b*32 +: 32], exp_block[b*32 +: 32], "victim block word");
        end
        check_word(rd, pattern_word(a), "third tag data");
        reads = rd_count;
        access(1'b0, vaddr, 4'h0, 32'h0, rd, lat, beat);   // comes back from memory
        assert (rd_count == reads + 1) else stop_on_error("evicted block was still resident");
        check_word(rd, way_word[vw], "reloaded evicted word");
    endtask

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with tests still running", cycles);
        $display("Checks failed");
        $fatal(1, "timeout");
    end

    initial begin
        reset  = 1'b1;
        valid  = 1'b0;
        op     = 1'b0;
        index  = '0;
        tag    = '0;
        offset = '0;
        wstrb  = '0;
        wdata  = '0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        reset_state();
        read_miss_then_hit();
        write_hit_strobes();
        write_miss_merge();
        dirty_eviction();
        if (dut.u_asserts.failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: bench/cache_asserts.sv
`timescale 1ns/1ps

module cache_asserts (
    input logic clk,
    input logic reset,
    input logic addr_ok,
    input logic rd_req,
    input logic rd_rdy,
    input logic wr_req,
    input logic wr_rdy
);

    int failures = 0;   // failed assertion count

    // one memory request at a time
    assert property (@(posedge clk) disable iff (reset) !(rd_req && wr_req))
        else begin
            $error("rd_req and wr_req high together");
            failures++;
        end

    assert property (@(posedge clk) disable iff (reset) (rd_req && !rd_rdy) |=> rd_req)
        else begin
            $error("rd_req dropped before rd_rdy");
            failures++;
        end

    assert property (@(posedge clk) disable iff (reset) (wr_req && !wr_rdy) |=> wr_req)
        else begin
            $error("wr_req dropped before wr_rdy");
            failures++;
        end

    assert property (@(posedge clk) disable iff (reset) (rd_req || wr_req) |-> !addr_ok)
        else begin
            $error("addr_ok high during a memory request");
            failures++;
        end

endmodule

bind cache_top cache_asserts u_asserts (
    .clk     (clk),
    .reset   (reset),
    .addr_ok (addr_ok),
    .rd_req  (rd_req),
    .rd_rdy  (rd_rdy),
    .wr_req  (wr_req),
    .wr_rdy  (wr_rdy)
);

// File: rtl/cache_top.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       valid,
    input  logic                       op,
    input  cache_pkg::index_t          index,
    input  cache_pkg::tag_t            tag,
    input  logic [`CACHE_OFFSET_W-1:0] offset,
    input  cache_pkg::strb_t           wstrb,
    input  cache_pkg::word_t           wdata,
    output logic                       addr_ok,
    output logic                       data_ok,
    output cache_pkg::word_t           rdata,
    output logic                       rd_req,
    output logic [`CACHE_WORD_W-1:0]   rd_addr,
    input  logic                       rd_rdy,
    input  logic                       ret_valid,
    input  logic                       ret_last,
    input  cache_pkg::word_t           ret_data,
    output logic                       wr_req,
    output logic [`CACHE_WORD_W-1:0]   wr_addr,
    output cache_pkg::block_t          wr_data,
    input  logic                       wr_rdy
);

    cache_pkg::tag_t req_tag;  // buffered tag for hit compare

    tag_port_if  tag_if ();
    data_port_if data_if ();

    cache_ctrl u_ctrl (
        .tp (tag_if.ctrl),
        .dp (data_if.ctrl),
        .*
    );

    tag_array u_tag (
        .clk     (clk),
        .reset   (reset),
        .tp      (tag_if.array),
        .req_tag (req_tag)
    );

    data_array u_data (
        .clk (clk),
        .dp  (data_if.array)
    );

endmodule

// File: rtl/cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_ctrl (
    input  logic                       clk,
    input  logic                       reset,
    // CPU side
    input  logic                       valid,
    input  logic                       op,      // 1 = write
    input  cache_pkg::index_t          index,
    input  cache_pkg::tag_t            tag,
    input  logic [`CACHE_OFFSET_W-1:0] offset,
    input  cache_pkg::strb_t           wstrb,
    input  cache_pkg::word_t           wdata,
    output logic                       addr_ok,
    output logic                       data_ok,
    output cache_pkg::word_t           rdata,
    // memory side
    output logic                       rd_req,
    output logic [`CACHE_WORD_W-1:0]   rd_addr,
    input  logic                       rd_rdy,
    input  logic                       ret_valid,
    input  logic                       ret_last,
    input  cache_pkg::word_t           ret_data,
    output logic                       wr_req,
    output logic [`CACHE_WORD_W-1:0]   wr_addr,
    output cache_pkg::block_t          wr_data,
    input  logic                       wr_rdy,
    // arrays
    tag_port_if.ctrl                   tp,
    data_port_if.ctrl                  dp,
    output cache_pkg::tag_t            req_tag
);

    cache_pkg::cache_state_t state, state_nxt;

    // request buffer
    logic              reg_op;
    cache_pkg::index_t reg_index;
    cache_pkg::bank_t  reg_bank;
    cache_pkg::strb_t  reg_wstrb;
    cache_pkg::word_t  reg_wdata;

    // hit-write buffer
    logic              hw_pending;
    logic              hw_way;
    cache_pkg::bank_t  hw_bank;
    cache_pkg::index_t hw_index;
    cache_pkg::strb_t  hw_strb;
    cache_pkg::word_t  hw_data;

    cache_pkg::bank_t  refill_cnt;
    logic [2:0]        lfsr;
    logic              victim;
    logic              accept, hit, hit_way, in_refill, refill_done;
    cache_pkg::word_t  merged_word, refill_word;

    assign addr_ok     = (state == cache_pkg::idle) && !hw_pending;
    assign accept      = valid && addr_ok;
    assign hit         = |tp.way_hit;
    assign hit_way     = tp.way_hit[1];
    assign victim      = lfsr[0];
    assign in_refill   = (state == cache_pkg::refill);
    assign refill_done = in_refill && ret_valid && ret_last;

    always_comb begin
        state_nxt = state;
        case (state)
            cache_pkg::idle:    if (accept) state_nxt = cache_pkg::lookup;
            cache_pkg::lookup:  state_nxt = hit ? cache_pkg::idle : cache_pkg::miss;
            cache_pkg::miss:    if (!tp.victim_dirty || wr_rdy) state_nxt = cache_pkg::replace;
            cache_pkg::replace: if (rd_rdy) state_nxt = cache_pkg::refill;
            cache_pkg::refill:  if (ret_valid && ret_last) state_nxt = cache_pkg::idle;
            default:            state_nxt = cache_pkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= cache_pkg::idle;
            hw_pending <= 1'b0;
            refill_cnt <= '0;
            lfsr       <= `CACHE_LFSR_SEED;
        end else begin
            state      <= state_nxt;
            hw_pending <= (state == cache_pkg::lookup) && hit && reg_op;  // one cycle only
            if (in_refill && ret_valid) refill_cnt <= refill_cnt + 2'd1;
            if (refill_done) lfsr <= {lfsr[0], lfsr[2] ^ lfsr[0], lfsr[1]};
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            reg_op    <= op;
            reg_index <= index;
            req_tag   <= tag;
            reg_bank  <= offset[3:2];
            reg_wstrb <= wstrb;
            reg_wdata <= wdata;
        end
        if (state == cache_pkg::lookup) begin
            hw_way   <= hit_way;
            hw_bank  <= reg_bank;
            hw_index <= reg_index;
            hw_strb  <= reg_wstrb;
            hw_data  <= reg_wdata;
        end
    end

    // store bytes win over the returned word
    always_comb begin
        for (int i = 0; i < `CACHE_STRB_W; i++) begin
            merged_word[i*8 +: 8] = reg_wstrb[i] ? reg_wdata[i*8 +: 8] : ret_data[i*8 +: 8];
        end
    end
    assign refill_word = (reg_op && refill_cnt == reg_bank) ? merged_word : ret_data;

    // array side
    assign tp.index      = accept ? index : (hw_pending ? hw_index : reg_index);
    assign tp.read_en    = accept;
    assign tp.refill_tag = req_tag;
    assign tp.victim_way = victim;
    assign dp.index      = tp.index;
    assign dp.read_en    = accept;
    assign dp.wdata      = hw_pending ? hw_data : refill_word;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            tp.refill_we[w] = refill_done && (victim == w[0]);
            tp.dirty_set[w] = (hw_pending && hw_way == w[0]) || (tp.refill_we[w] && reg_op);
            tp.dirty_clr[w] = tp.refill_we[w] && !reg_op;
            for (int b = 0; b < `CACHE_BANKS; b++) begin
                if (hw_pending && hw_way == w[0] && hw_bank == b[1:0])
                    dp.bank_we[w][b] = hw_strb;
                else if (in_refill && ret_valid && victim == w[0] && refill_cnt == b[1:0])
                    dp.bank_we[w][b] = '1;
                else
                    dp.bank_we[w][b] = '0;
            end
        end
    end

    // CPU outputs
    assign data_ok = ((state == cache_pkg::lookup) && (hit || reg_op))
                   || (in_refill && ret_valid && !reg_op && refill_cnt == reg_bank);
    assign rdata   = in_refill ? ret_data
                   : dp.way_block[hit_way][reg_bank*`CACHE_WORD_W +: `CACHE_WORD_W];

    // memory outputs move whole blocks only
    assign rd_req  = (state == cache_pkg::replace);
    assign rd_addr = {req_tag, reg_index, {`CACHE_OFFSET_W{1'b0}}};
    assign wr_req  = (state == cache_pkg::miss) && tp.victim_dirty;
    assign wr_addr = {tp.way_tag[victim], reg_index, {`CACHE_OFFSET_W{1'b0}}};
    assign wr_data = dp.way_block[victim];

endmodule

// File: rtl/data_array.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module data_array (
    input  logic       clk,
    data_port_if.array dp
);

    cache_pkg::word_t [1:0][`CACHE_BANKS-1:0] bank_rd;

    for (genvar w = 0; w < 2; w++) begin : g_way
        for (genvar b = 0; b < `CACHE_BANKS; b++) begin : g_bank
            cache_pkg::word_t bit_mask;

            // expand byte strobes to a bit mask
            always_comb begin
                for (int i = 0; i < `CACHE_STRB_W; i++) begin
                    bit_mask[i*8 +: 8] = {8{dp.bank_we[w][b][i]}};
                end
            end

            sram_1p #(
                .entry_t (cache_pkg::word_t),
                .depth   (`CACHE_SETS)
            ) u_bank (
                .clk   (clk),
                .en    (dp.read_en | (|dp.bank_we[w][b])),
                .addr  (dp.index),
                .wmask (bit_mask),
                .wdata (dp.wdata),
                .rdata (bank_rd[w][b])
            );
        end

        assign dp.way_block[w] = {bank_rd[w][3], bank_rd[w][2], bank_rd[w][1], bank_rd[w][0]};
    end

endmodule

// File: rtl/tag_array.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module tag_array (
    input  logic            clk,
    input  logic            reset,
    tag_port_if.array       tp,
    input  cache_pkg::tag_t req_tag
);

    localparam cache_pkg::tagv_t full_mask = '1;

    cache_pkg::tagv_t [1:0]          tagv_rd;
    cache_pkg::tagv_t                tagv_new;
    logic [1:0][`CACHE_SETS-1:0]     dirty;
    cache_pkg::index_t               idx_q;   // set of the last lookup

    assign tagv_new = '{tag: tp.refill_tag, valid: 1'b1};

    for (genvar w = 0; w < 2; w++) begin : g_way
        sram_1p #(
            .entry_t (cache_pkg::tagv_t),
            .depth   (`CACHE_SETS)
        ) u_tagv (
            .clk   (clk),
            .en    (tp.read_en | tp.refill_we[w]),
            .addr  (tp.index),
            .wmask (tp.refill_we[w] ? full_mask : '0),
            .wdata (tagv_new),
            .rdata (tagv_rd[w])
        );

        assign tp.way_hit[w] = tagv_rd[w].valid && (tagv_rd[w].tag == req_tag);
        assign tp.way_tag[w] = tagv_rd[w].tag;
    end

    always_ff @(posedge clk) begin
        if (tp.read_en) idx_q <= tp.index;
    end

    // dirty bits, one per set and way
    always_ff @(posedge clk) begin
        if (reset) begin
            dirty <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (tp.dirty_set[w]) dirty[w][tp.index] <= 1'b1;
                else if (tp.dirty_clr[w]) dirty[w][tp.index] <= 1'b0;
            end
        end
    end

    // an invalid victim never needs a write-back
    assign tp.victim_dirty = dirty[tp.victim_way][idx_q] && tagv_rd[tp.victim_way].valid;

endmodule

// File: rtl/sram_1p.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module sram_1p #(
    parameter type entry_t = logic [31:0],
    parameter int  depth   = `CACHE_SETS
) (
    input  logic              clk,
    input  logic              en,
    input  cache_pkg::index_t addr,
    input  entry_t            wmask,
    input  entry_t            wdata,
    output entry_t            rdata
);

    entry_t mem [depth];

    always_ff @(posedge clk) begin
        if (en) begin
            if (|wmask) begin
                mem[addr] <= entry_t'((mem[addr] & ~wmask) | (wdata & wmask));
            end else begin
                rdata <= mem[addr];  // output holds otherwise
            end
        end
    end

endmodule

// File: rtl/cache_ifs.sv
`timescale 1ns/1ps

interface tag_port_if;
    cache_pkg::index_t       index;
    logic                    read_en;
    logic [1:0]              refill_we;    // one per way
    cache_pkg::tag_t         refill_tag;
    logic [1:0]              dirty_set;
    logic [1:0]              dirty_clr;
    logic                    victim_way;
    logic [1:0]              way_hit;
    cache_pkg::tag_t [1:0]   way_tag;
    logic                    victim_dirty;

    modport ctrl (
        output index, read_en, refill_we, refill_tag, dirty_set, dirty_clr, victim_way,
        input  way_hit, way_tag, victim_dirty
    );

    modport array (
        input  index, read_en, refill_we, refill_tag, dirty_set, dirty_clr, victim_way,
        output way_hit, way_tag, victim_dirty
    );
endinterface

interface data_port_if;
    cache_pkg::index_t           index;
    logic                        read_en;
    cache_pkg::strb_t [1:0][3:0] bank_we;   // [way][bank]
    cache_pkg::word_t            wdata;
    cache_pkg::block_t [1:0]     way_block;

    modport ctrl (
        output index, read_en, bank_we, wdata,
        input  way_block
    );

    modport array (
        input  index, read_en, bank_we, wdata,
        output way_block
    );
endinterface

// File: rtl/cache_pkg.sv
`include "cache_defs.svh"

package cache_pkg;

    typedef logic [`CACHE_TAG_W-1:0]    tag_t;
    typedef logic [`CACHE_INDEX_W-1:0]  index_t;
    typedef logic [1:0]                 bank_t;   // word within a block
    typedef logic [`CACHE_WORD_W-1:0]   word_t;
    typedef logic [`CACHE_STRB_W-1:0]   strb_t;
    typedef logic [`CACHE_BLOCK_W-1:0]  block_t;  // bank 0 in the low word

    typedef struct packed {
        tag_t tag;
        logic valid;
    } tagv_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        miss,
        replace,
        refill
    } cache_state_t;

endpackage

// File: include/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// address split into tag, index and offset
`define CACHE_TAG_W     20
`define CACHE_INDEX_W   8
`define CACHE_OFFSET_W  4

// geometry
`define CACHE_SETS      256
`define CACHE_BANKS     4

// data widths
`define CACHE_WORD_W    32
`define CACHE_BLOCK_W   128
`define CACHE_STRB_W    4

// replacement LFSR start value
`define CACHE_LFSR_SEED 3'b111

`endif
